/* hdl/comms_pkg.sv */
// Link test subsystem shared definitions
// Widths, register map, ID words and timeouts

package comms_pkg;

   // ------------------------------------------------------------
   // Widths
   // ------------------------------------------------------------
   typedef logic [23:0] lb_addr_t;
   typedef logic [31:0] lb_data_t;
   typedef logic [31:0] word_t;
   typedef logic [15:0] cnt_t;
   // One word every rate+1 cycles
   typedef logic [4:0]  rate_t;
   typedef logic [2:0]  step_t;

   localparam int FIFO_DEPTH  = 16;
   localparam int LOS_TIMEOUT = 64;

   typedef logic [$clog2(FIFO_DEPTH)-1:0] fifo_ptr_t;
   // Fill count needs one more bit to reach FIFO_DEPTH
   typedef logic [$clog2(FIFO_DEPTH):0]   fifo_cnt_t;
   typedef logic [$clog2(LOS_TIMEOUT)-1:0] idle_t;

   // ------------------------------------------------------------
   // ID words
   // ------------------------------------------------------------
   localparam lb_data_t INFO0_WORD    = "LINK";
   localparam lb_data_t INFO1_WORD    = "TEST";
   localparam lb_data_t BAD_ADDR_WORD = 32'hdeadf00d;

   // ------------------------------------------------------------
   // Register map
   // ------------------------------------------------------------
   localparam lb_addr_t RD_INFO0     = 24'd0;
   localparam lb_addr_t RD_INFO1     = 24'd1;
   localparam lb_addr_t RD_FRAME_CNT = 24'd2;
   localparam lb_addr_t RD_LOS       = 24'd3;
   localparam lb_addr_t RD_LAST_WORD = 24'd4;
   localparam lb_addr_t RD_MATCH0    = 24'd5;
   localparam lb_addr_t RD_MATCH1    = 24'd6;
   localparam lb_addr_t RD_ERR_CNT0  = 24'd7;
   localparam lb_addr_t RD_ERR_CNT1  = 24'd8;
   localparam lb_addr_t RD_OVERFLOW  = 24'd9;

   localparam lb_addr_t WR_TRANSMIT_EN = 24'd0;
   localparam lb_addr_t WR_DISABLE     = 24'd1;
   localparam lb_addr_t WR_RATE        = 24'd2;
   localparam lb_addr_t WR_TEST_MODE   = 24'd3;
   localparam lb_addr_t WR_INC_STEP    = 24'd4;
   localparam lb_addr_t WR_USR_DATA    = 24'd5;

   // Write registers read back at this offset
   localparam lb_addr_t RB_BASE = 24'h20;

endpackage

/* hdl/pattern_gen.sv */
// Test pattern generator
// Sends incrementing or fixed test words at a programmable rate

module pattern_gen (
   input  logic             lb_clk,
   input  logic             rst_n_i,
   input  logic             transmit_en_i,
   input  logic             disable_i,
   input  comms_pkg::rate_t rate_i,
   input  logic             test_mode_i,
   input  comms_pkg::step_t inc_step_i,
   input  comms_pkg::word_t usr_data_i,
   output logic             tx_valid_o,
   output comms_pkg::word_t tx_word_o
);

   logic             run;
   logic             fire;
   comms_pkg::rate_t rate_cnt_q;
   logic             strobe_q;
   comms_pkg::word_t acc_q;
   logic [5:0]       gap_q;

   assign run  = transmit_en_i && !disable_i;
   assign fire = run && (rate_cnt_q == '0);

   always_ff @(posedge lb_clk) begin
      if (!rst_n_i || !run) begin
         rate_cnt_q <= '0;
         strobe_q   <= 1'b0;
         acc_q      <= '0;
      end else if (fire) begin
         rate_cnt_q <= rate_i;
         strobe_q   <= 1'b1;
         acc_q      <= acc_q + comms_pkg::word_t'(inc_step_i);
      end else begin
         rate_cnt_q <= rate_cnt_q - comms_pkg::rate_t'(1);
         strobe_q   <= 1'b0;
      end
   end

   always_ff @(posedge lb_clk) begin
      if (fire) begin
         tx_word_o <= test_mode_i ? usr_data_i : acc_q;
      end
   end

   // Strobe is cut as soon as the enable drops
   assign tx_valid_o = strobe_q && run;

   // ------------------------------------------------------------
   // Strobe spacing
   // ------------------------------------------------------------
   always_ff @(posedge lb_clk) begin
      if (!rst_n_i || !run) begin
         gap_q <= '1;
      end else if (tx_valid_o) begin
         gap_q <= '0;
      end else if (gap_q != '1) begin
         gap_q <= gap_q + 6'd1;
      end
   end

   a_strobe_spacing: assert property (@(posedge lb_clk) disable iff (!rst_n_i)
      tx_valid_o |-> (gap_q >= 6'(rate_i)))
      else $error("pattern_gen: strobes closer than rate+1 cycles");

endmodule

/* hdl/link_fifo.sv */
// Link channel model
// Auto-draining FIFO that can flip bit 0 of one written word

module link_fifo (
   input  logic             lb_clk,
   input  logic             rst_n_i,
   input  logic             wr_i,
   input  comms_pkg::word_t wr_word_i,
   input  logic             fault_inject_i,
   output logic             rd_valid_o,
   output comms_pkg::word_t rd_word_o,
   output logic             overflow_o
);

   comms_pkg::word_t     mem [comms_pkg::FIFO_DEPTH];
   comms_pkg::fifo_ptr_t wr_ptr_q;
   comms_pkg::fifo_ptr_t rd_ptr_q;
   comms_pkg::fifo_cnt_t count_q;
   logic                 fault_q;
   logic                 do_wr;
   logic                 do_rd;

   assign do_rd = (count_q != '0);
   assign do_wr = wr_i && (count_q != comms_pkg::fifo_cnt_t'(comms_pkg::FIFO_DEPTH));

   always_ff @(posedge lb_clk) begin
      if (do_wr) begin
         mem[wr_ptr_q] <= wr_word_i ^ comms_pkg::word_t'(fault_q);
      end
      if (do_rd) begin
         rd_word_o <= mem[rd_ptr_q];
      end
   end

   always_ff @(posedge lb_clk) begin
      if (!rst_n_i) begin
         wr_ptr_q   <= '0;
         rd_ptr_q   <= '0;
         count_q    <= '0;
         rd_valid_o <= 1'b0;
         fault_q    <= 1'b0;
         overflow_o <= 1'b0;
      end else begin
         if (do_wr) wr_ptr_q <= wr_ptr_q + comms_pkg::fifo_ptr_t'(1);
         if (do_rd) rd_ptr_q <= rd_ptr_q + comms_pkg::fifo_ptr_t'(1);
         rd_valid_o <= do_rd;
         case ({do_wr, do_rd})
            2'b10:   count_q <= count_q + comms_pkg::fifo_cnt_t'(1);
            2'b01:   count_q <= count_q - comms_pkg::fifo_cnt_t'(1);
            default: count_q <= count_q;
         endcase
         // Armed until the next accepted write, which it corrupts
         if (fault_inject_i) fault_q <= 1'b1;
         else if (do_wr) fault_q <= 1'b0;
         if (wr_i && !do_wr) overflow_o <= 1'b1;
      end
   end

   // Fill count bounded and in step with the pointers
   a_count_bound: assert property (@(posedge lb_clk) disable iff (!rst_n_i)
      (count_q <= comms_pkg::fifo_cnt_t'(comms_pkg::FIFO_DEPTH)) &&
      (comms_pkg::fifo_ptr_t'(count_q) == comms_pkg::fifo_ptr_t'(wr_ptr_q - rd_ptr_q)));
   a_no_empty_read: assert property (@(posedge lb_clk) disable iff (!rst_n_i)
      do_rd |-> ((rd_ptr_q != wr_ptr_q) ||
                 (count_q == comms_pkg::fifo_cnt_t'(comms_pkg::FIFO_DEPTH))));

endmodule

/* hdl/pattern_check.sv */
// Receive pattern checker
// Counts frames, compares against the expected pattern, detects loss of signal

module pattern_check (
   input  logic             lb_clk,
   input  logic             rst_n_i,
   input  logic             rx_valid_i,
   input  comms_pkg::word_t rx_word_i,
   input  logic             test_mode_i,
   input  comms_pkg::step_t inc_step_i,
   input  comms_pkg::word_t usr_data_i,
   output comms_pkg::cnt_t  frame_cnt_o,
   output logic             los_o,
   output comms_pkg::word_t last_word_o,
   output logic             match0_o,
   output logic             match1_o,
   output comms_pkg::cnt_t  err_cnt0_o,
   output comms_pkg::cnt_t  err_cnt1_o
);

   comms_pkg::idle_t idle_q;
   logic             first_q;
   logic             seed;
   comms_pkg::word_t expect_word;
   logic             ok0;
   logic             ok1;

   function automatic comms_pkg::cnt_t sat_inc(comms_pkg::cnt_t v);
      return (v == '1) ? v : v + comms_pkg::cnt_t'(1);
   endfunction

   // No prediction for the first word after reset or a long gap
   assign seed        = first_q || los_o;
   assign expect_word = last_word_o + comms_pkg::word_t'(inc_step_i);
   assign ok0         = (rx_word_i == expect_word);
   assign ok1         = (rx_word_i == usr_data_i);

   always_ff @(posedge lb_clk) begin
      if (!rst_n_i) begin
         idle_q      <= '0;
         los_o       <= 1'b0;
         first_q     <= 1'b1;
         frame_cnt_o <= '0;
         last_word_o <= '0;
         match0_o    <= 1'b0;
         match1_o    <= 1'b0;
         err_cnt0_o  <= '0;
         err_cnt1_o  <= '0;
      end else if (rx_valid_i) begin
         idle_q      <= '0;
         los_o       <= 1'b0;
         first_q     <= 1'b0;
         frame_cnt_o <= frame_cnt_o + comms_pkg::cnt_t'(1);
         last_word_o <= rx_word_i;
         if (test_mode_i) begin
            match1_o <= ok1;
            if (!ok1) err_cnt1_o <= sat_inc(err_cnt1_o);
         end else if (!seed) begin
            match0_o <= ok0;
            if (!ok0) err_cnt0_o <= sat_inc(err_cnt0_o);
         end
      end else begin
         // Idle cycle
         if (idle_q != comms_pkg::idle_t'(comms_pkg::LOS_TIMEOUT - 1)) begin
            idle_q <= idle_q + comms_pkg::idle_t'(1);
         end else begin
            los_o <= 1'b1;
         end
      end
   end

endmodule

/* hdl/comms_regbank.sv */
// Local-bus register bank for the link test subsystem
// Generator control registers and checker status read-back

module comms_regbank (
   input  logic                lb_clk,
   input  logic                rst_n_i,
   input  logic                lb_valid_i,
   input  logic                lb_rnw_i,
   input  comms_pkg::lb_addr_t lb_addr_i,
   input  comms_pkg::lb_data_t lb_wdata_i,
   input  comms_pkg::cnt_t     frame_cnt_i,
   input  logic                los_i,
   input  comms_pkg::word_t    last_word_i,
   input  logic                match0_i,
   input  logic                match1_i,
   input  comms_pkg::cnt_t     err_cnt0_i,
   input  comms_pkg::cnt_t     err_cnt1_i,
   input  logic                overflow_i,
   output comms_pkg::lb_data_t lb_rdata_o,
   output logic                transmit_en_o,
   output logic                pgen_disable_o,
   output comms_pkg::rate_t    pgen_rate_o,
   output logic                pgen_test_mode_o,
   output comms_pkg::step_t    pgen_inc_step_o,
   output comms_pkg::word_t    pgen_usr_data_o
);

   comms_pkg::lb_addr_t rd_addr_q;
   logic                rd_pend_q;
   comms_pkg::lb_data_t rd_mux;

   // ------------------------------------------------------------
   // Read path
   // ------------------------------------------------------------
   always_ff @(posedge lb_clk) begin
      if (lb_valid_i && lb_rnw_i) begin
         rd_addr_q <= lb_addr_i;
      end
   end

   always_comb begin
      case (rd_addr_q)
         comms_pkg::RD_INFO0:     rd_mux = comms_pkg::INFO0_WORD;
         comms_pkg::RD_INFO1:     rd_mux = comms_pkg::INFO1_WORD;
         comms_pkg::RD_FRAME_CNT: rd_mux = comms_pkg::lb_data_t'(frame_cnt_i);
         comms_pkg::RD_LOS:       rd_mux = comms_pkg::lb_data_t'(los_i);
         comms_pkg::RD_LAST_WORD: rd_mux = last_word_i;
         comms_pkg::RD_MATCH0:    rd_mux = comms_pkg::lb_data_t'(match0_i);
         comms_pkg::RD_MATCH1:    rd_mux = comms_pkg::lb_data_t'(match1_i);
         comms_pkg::RD_ERR_CNT0:  rd_mux = comms_pkg::lb_data_t'(err_cnt0_i);
         comms_pkg::RD_ERR_CNT1:  rd_mux = comms_pkg::lb_data_t'(err_cnt1_i);
         comms_pkg::RD_OVERFLOW:  rd_mux = comms_pkg::lb_data_t'(overflow_i);
         // Write register read-back
         comms_pkg::RB_BASE + comms_pkg::WR_TRANSMIT_EN:
            rd_mux = comms_pkg::lb_data_t'(transmit_en_o);
         comms_pkg::RB_BASE + comms_pkg::WR_DISABLE:
            rd_mux = comms_pkg::lb_data_t'(pgen_disable_o);
         comms_pkg::RB_BASE + comms_pkg::WR_RATE:
            rd_mux = comms_pkg::lb_data_t'(pgen_rate_o);
         comms_pkg::RB_BASE + comms_pkg::WR_TEST_MODE:
            rd_mux = comms_pkg::lb_data_t'(pgen_test_mode_o);
         comms_pkg::RB_BASE + comms_pkg::WR_INC_STEP:
            rd_mux = comms_pkg::lb_data_t'(pgen_inc_step_o);
         comms_pkg::RB_BASE + comms_pkg::WR_USR_DATA:
            rd_mux = pgen_usr_data_o;
         default:                 rd_mux = comms_pkg::BAD_ADDR_WORD;
      endcase
   end

   // Data lands two cycles after the read strobe and holds until the next read
   always_ff @(posedge lb_clk) begin
      if (!rst_n_i) begin
         rd_pend_q  <= 1'b0;
         lb_rdata_o <= '0;
      end else begin
         rd_pend_q <= lb_valid_i && lb_rnw_i;
         if (rd_pend_q) lb_rdata_o <= rd_mux;
      end
   end

   // ------------------------------------------------------------
   // Write path
   // ------------------------------------------------------------
   always_ff @(posedge lb_clk) begin
      if (!rst_n_i) begin
         transmit_en_o    <= 1'b0;
         pgen_disable_o   <= 1'b0;
         pgen_rate_o      <= '0;
         pgen_test_mode_o <= 1'b0;
         pgen_inc_step_o  <= '0;
         pgen_usr_data_o  <= '0;
      end else if (lb_valid_i && !lb_rnw_i) begin
         case (lb_addr_i)
            comms_pkg::WR_TRANSMIT_EN: transmit_en_o    <= lb_wdata_i[0];
            comms_pkg::WR_DISABLE:     pgen_disable_o   <= lb_wdata_i[0];
            comms_pkg::WR_RATE:        pgen_rate_o      <= comms_pkg::rate_t'(lb_wdata_i);
            comms_pkg::WR_TEST_MODE:   pgen_test_mode_o <= lb_wdata_i[0];
            comms_pkg::WR_INC_STEP:    pgen_inc_step_o  <= comms_pkg::step_t'(lb_wdata_i);
            comms_pkg::WR_USR_DATA:    pgen_usr_data_o  <= lb_wdata_i;
            default:                   ;
         endcase
      end
   end

   a_rnw_known: assert property (@(posedge lb_clk) disable iff (!rst_n_i)
      lb_valid_i |-> !$isunknown(lb_rnw_i));

endmodule

/* hdl/comms_top.sv */
// Link test subsystem top level
// Register bank, pattern generator, channel FIFO and checker

module comms_top (
   input  logic                lb_clk,
   input  logic                rst_n_i,
   input  logic                lb_valid_i,
   input  logic                lb_rnw_i,
   input  comms_pkg::lb_addr_t lb_addr_i,
   input  comms_pkg::lb_data_t lb_wdata_i,
   output comms_pkg::lb_data_t lb_rdata_o,
   input  logic                fault_inject_i
);

   logic             tx_transmit_en;
   logic             pgen_disable;
   comms_pkg::rate_t pgen_rate;
   logic             pgen_test_mode;
   comms_pkg::step_t pgen_inc_step;
   comms_pkg::word_t pgen_usr_data;
   logic             tx_valid;
   comms_pkg::word_t tx_word;
   logic             rx_valid;
   comms_pkg::word_t rx_word;
   logic             overflow;
   comms_pkg::cnt_t  frame_cnt;
   logic             los;
   comms_pkg::word_t last_word;
   logic             match0;
   logic             match1;
   comms_pkg::cnt_t  err_cnt0;
   comms_pkg::cnt_t  err_cnt1;

   comms_regbank comms_regbank_inst (
      .lb_clk           (lb_clk),
      .rst_n_i          (rst_n_i),
      .lb_valid_i       (lb_valid_i),
      .lb_rnw_i         (lb_rnw_i),
      .lb_addr_i        (lb_addr_i),
      .lb_wdata_i       (lb_wdata_i),
      .frame_cnt_i      (frame_cnt),
      .los_i            (los),
      .last_word_i      (last_word),
      .match0_i         (match0),
      .match1_i         (match1),
      .err_cnt0_i       (err_cnt0),
      .err_cnt1_i       (err_cnt1),
      .overflow_i       (overflow),
      .lb_rdata_o       (lb_rdata_o),
      .transmit_en_o    (tx_transmit_en),
      .pgen_disable_o   (pgen_disable),
      .pgen_rate_o      (pgen_rate),
      .pgen_test_mode_o (pgen_test_mode),
      .pgen_inc_step_o  (pgen_inc_step),
      .pgen_usr_data_o  (pgen_usr_data)
   );

   pattern_gen pattern_gen_inst (
      .lb_clk        (lb_clk),
      .rst_n_i       (rst_n_i),
      .transmit_en_i (tx_transmit_en),
      .disable_i     (pgen_disable),
      .rate_i        (pgen_rate),
      .test_mode_i   (pgen_test_mode),
      .inc_step_i    (pgen_inc_step),
      .usr_data_i    (pgen_usr_data),
      .tx_valid_o    (tx_valid),
      .tx_word_o     (tx_word)
   );

   link_fifo link_fifo_inst (
      .lb_clk         (lb_clk),
      .rst_n_i        (rst_n_i),
      .wr_i           (tx_valid),
      .wr_word_i      (tx_word),
      .fault_inject_i (fault_inject_i),
      .rd_valid_o     (rx_valid),
      .rd_word_o      (rx_word),
      .overflow_o     (overflow)
   );

   pattern_check pattern_check_inst (
      .lb_clk      (lb_clk),
      .rst_n_i     (rst_n_i),
      .rx_valid_i  (rx_valid),
      .rx_word_i   (rx_word),
      .test_mode_i (pgen_test_mode),
      .inc_step_i  (pgen_inc_step),
      .usr_data_i  (pgen_usr_data),
      .frame_cnt_o (frame_cnt),
      .los_o       (los),
      .last_word_o (last_word),
      .match0_o    (match0),
      .match1_o    (match1),
      .err_cnt0_o  (err_cnt0),
      .err_cnt1_o  (err_cnt1)
   );

endmodule

/* verification/comms_top_tb.sv */
// Testbench for the link test subsystem
// Replays bus operations from a golden file and checks the read data

module comms_top_tb;
   timeunit 1ns;
   timeprecision 100ps;

   logic                lb_clk;
   logic                rst_n;
   logic                lb_valid;
   logic                lb_rnw;
   comms_pkg::lb_addr_t lb_addr;
   comms_pkg::lb_data_t lb_wdata;
   comms_pkg::lb_data_t lb_rdata;
   logic                fault_inject;

   int data_errs;
   int cnt_errs;
   int other_errs;

   comms_top comms_top_inst (
      .lb_clk         (lb_clk),
      .rst_n_i        (rst_n),
      .lb_valid_i     (lb_valid),
      .lb_rnw_i       (lb_rnw),
      .lb_addr_i      (lb_addr),
      .lb_wdata_i     (lb_wdata),
      .lb_rdata_o     (lb_rdata),
      .fault_inject_i (fault_inject)
   );

   initial begin
      lb_clk = 1'b0;
      forever #2 lb_clk = ~lb_clk;
   end

   function automatic string reg_name(comms_pkg::lb_addr_t addr);
      case (addr)
         comms_pkg::RD_INFO0:     return "info0";
         comms_pkg::RD_INFO1:     return "info1";
         comms_pkg::RD_FRAME_CNT: return "frame_cnt";
         comms_pkg::RD_LOS:       return "los";
         comms_pkg::RD_LAST_WORD: return "last_word";
         comms_pkg::RD_MATCH0:    return "match0";
         comms_pkg::RD_MATCH1:    return "match1";
         comms_pkg::RD_ERR_CNT0:  return "err_cnt0";
         comms_pkg::RD_ERR_CNT1:  return "err_cnt1";
         comms_pkg::RD_OVERFLOW:  return "overflow";
         comms_pkg::RB_BASE + comms_pkg::WR_TRANSMIT_EN: return "transmit_en";
         comms_pkg::RB_BASE + comms_pkg::WR_DISABLE:     return "pgen_disable";
         comms_pkg::RB_BASE + comms_pkg::WR_RATE:        return "pgen_rate";
         comms_pkg::RB_BASE + comms_pkg::WR_TEST_MODE:   return "pgen_test_mode";
         comms_pkg::RB_BASE + comms_pkg::WR_INC_STEP:    return "pgen_inc_step";
         comms_pkg::RB_BASE + comms_pkg::WR_USR_DATA:    return "pgen_usr_data";
         default:                 return "unmapped";
      endcase
   endfunction

   // ------------------------------------------------------------
   // Compare tasks
   // ------------------------------------------------------------
   task automatic check_data(string name, comms_pkg::lb_data_t exp, comms_pkg::lb_data_t act);
      if (act !== exp) begin
         data_errs++;
         $display("Fail %0d ns %s expected %h got %h", $time, name, exp, act);
      end
   endtask

   task automatic check_cnt(string name, comms_pkg::cnt_t exp, comms_pkg::cnt_t act);
      if (act !== exp) begin
         cnt_errs++;
         $display("Fail %0d ns %s expected %0d got %0d", $time, name, exp, act);
      end
   endtask

   // ------------------------------------------------------------
   // Bus operations start 1 ns after a rising edge
   // ------------------------------------------------------------
   task automatic next_cycle();
      @(posedge lb_clk);
      #1;
   endtask

   task automatic bus_write(comms_pkg::lb_addr_t addr, comms_pkg::lb_data_t data);
      lb_valid = 1'b1;
      lb_rnw   = 1'b0;
      lb_addr  = addr;
      lb_wdata = data;
      next_cycle();
      lb_valid = 1'b0;
   endtask

   task automatic bus_read(comms_pkg::lb_addr_t addr, output comms_pkg::lb_data_t data);
      logic pend_prev;
      logic arrived;
      int   n;
      lb_valid = 1'b1;
      lb_rnw   = 1'b1;
      lb_addr  = addr;
      arrived  = 1'b0;
      n        = 0;
      // Data is loaded on the edge after the pending flag was seen
      while (!arrived && n < 2) begin
         pend_prev = comms_top_inst.comms_regbank_inst.rd_pend_q;
         next_cycle();
         lb_valid = 1'b0;
         n++;
         if (pend_prev) arrived = 1'b1;
      end
      data = lb_rdata;
      if (!arrived) begin
         other_errs++;
         $display("Read data did not arrive within 2 cycles, address %h", addr);
      end
   endtask

   task automatic check_read(comms_pkg::lb_addr_t addr, comms_pkg::lb_data_t exp);
      comms_pkg::lb_data_t got;
      bus_read(addr, got);
      if (addr == comms_pkg::RD_FRAME_CNT || addr == comms_pkg::RD_ERR_CNT0 ||
          addr == comms_pkg::RD_ERR_CNT1) begin
         check_cnt(reg_name(addr), comms_pkg::cnt_t'(exp), comms_pkg::cnt_t'(got));
         if (got[31:16] != '0) begin
            other_errs++;
            $display("Counter read at address %h has nonzero upper bits", addr);
         end
      end else begin
         check_data(reg_name(addr), exp, got);
      end
   endtask

   task automatic pulse_fault();
      fault_inject = 1'b1;
      next_cycle();
      fault_inject = 1'b0;
   endtask

   // ------------------------------------------------------------
   // Golden file replay
   // ------------------------------------------------------------
   task automatic run_golden();
      int          fd;
      int          fields;
      int          n;
      string       line;
      logic [7:0]  op;
      logic [31:0] a;
      logic [31:0] d;
      fd = $fopen("verification/comms_golden.txt", "r");
      if (fd == 0) begin
         other_errs++;
         $display("Cannot open the golden file verification/comms_golden.txt");
      end else begin
         while ($fgets(line, fd) != 0) begin
            op = (line.len() > 0) ? line[0] : "#";
            fields = 0;
            case (op)
               "W": fields = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, d);
               "R": fields = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, d);
               "D": fields = $sscanf(line.substr(1, line.len() - 1), "%d", n) + 1;
               "F", "#", "\n", "\r", " ": fields = 2;
               default: fields = 0;
            endcase
            if (fields != 2) begin
               other_errs++;
               $display("Malformed golden line: %s", line);
            end else if (op == "W") begin
               bus_write(a[23:0], d);
            end else if (op == "R") begin
               check_read(a[23:0], d);
            end else if (op == "D") begin
               repeat (n) next_cycle();
            end else if (op == "F") begin
               pulse_fault();
            end
         end
         $fclose(fd);
      end
   endtask

   initial begin
      data_errs    = 0;
      cnt_errs     = 0;
      other_errs   = 0;
      rst_n        = 1'b0;
      lb_valid     = 1'b0;
      lb_rnw       = 1'b0;
      lb_addr      = '0;
      lb_wdata     = '0;
      fault_inject = 1'b0;
      repeat (10) @(posedge lb_clk);
      #1;
      rst_n = 1'b1;
      check_data("lb_rdata_o", '0, lb_rdata);
      run_golden();
      $display("Errors: %0d data, %0d count, %0d other", data_errs, cnt_errs, other_errs);
      if (data_errs + cnt_errs + other_errs == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

/* verification/comms_golden.txt */
# Columns: op addr value, hex. W writes value, R reads addr and expects value.
# F pulses fault_inject_i, D n waits n idle cycles (decimal).
# ID words and unmapped reads
R 0 4c494e4b
R 1 54455354
R a deadf00d
R 26 deadf00d
R 2 0
R 7 0
# Control registers and read-back
W 2 3
W 4 2
W 3 0
W 5 a5a55a5a
W 1 1
W 6 ffffffff
R 22 3
R 24 2
R 23 0
R 25 a5a55a5a
R 21 1
W 1 0
R 21 0
R 20 0
# Incrementing run, rate 3 step 2, 10 words
W 0 1
D 38
W 0 0
D 4
R 2 a
R 5 1
R 7 0
R 4 12
R 9 0
# Idle past the LOS timeout
D 80
R 3 1
# Incrementing run with one corrupted word
W 0 1
D 10
F
D 27
W 0 0
D 4
R 3 0
R 2 14
R 7 2
R 5 1
R 4 12
R 9 0
# Fixed mode at full rate, 20 words then 17 words
W 3 1
W 5 c0ffee11
W 2 0
R 23 1
R 22 0
W 0 1
D 20
W 0 0
D 4
R 6 1
R 8 0
W 0 1
D 8
F
D 8
W 0 0
D 4
R 8 1
R 6 1
R 2 39
R 9 0

/* compile.f */
hdl/comms_pkg.sv
hdl/pattern_gen.sv
hdl/link_fifo.sv
hdl/pattern_check.sv
hdl/comms_regbank.sv
hdl/comms_top.sv
verification/comms_top_tb.sv

/* Makefile */
# Verilator build and run for the link test subsystem

TOP := comms_top_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing --assert --timescale 1ns/1ns -j 0 \
		--top-module $(TOP) -f compile.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir
